//--- flist.f
+incdir+verilog
verilog/tg_pkg.sv
verilog/tg_rand_num_gen.sv
verilog/tg_rand_burstcount_gen.sv
verilog/tg_cmd_decode.sv
verilog/tg_wb_execute.sv
verilog/tg_result_check.sv
verilog/tg_top.sv
verif/tg_wb_mem_model.sv
verif/tg_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tg_tb -f flist.f \
   -o tg_sim > sim.log 2>&1 && ./obj_dir/tg_sim >> sim.log 2>&1

cat sim.log
grep -q "sim failed" sim.log && echo "RESULT: FAIL" && exit 1
grep -q "sim passed" sim.log || { echo "RESULT: FAIL, no pass message in sim.log"; exit 1; }
echo "RESULT: PASS"
exit 0

//--- verif/tg_tb.sv
//////////////////////////////////////////////////////////////////////
// One clean run, then one run with a flipped read bit in burst one
// Concurrent assertions check the bus and the final status
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

module tg_tb;
   import tg_pkg::*;

   localparam int NUM          = `TG_NUM_BURSTS;
   localparam int DONE_TIMEOUT = 20000;

   logic        clk;
   logic        rst_n;
   logic        start;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   addr_t       wb_adr;
   data_t       wb_dat_o;
   data_t       wb_dat_i;
   logic        wb_ack;
   logic        done;
   logic [15:0] error_count;
   addr_t       first_error_addr;
   logic        corrupt_addr_en;
   addr_t       corrupt_addr;

   // Bus bookkeeping for the checks
   logic        cyc_q;
   logic        burst_end;
   logic [7:0]  ack_cnt;
   logic [7:0]  burst_total;
   addr_t       exp_adr;
   logic [7:0]  write_lens [0:NUM-1];
   logic [7:0]  exp_len;
   logic [15:0] exp_errors;

   tg_top tg_top_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .start            (start),
      .wb_cyc           (wb_cyc),
      .wb_stb           (wb_stb),
      .wb_we            (wb_we),
      .wb_adr           (wb_adr),
      .wb_dat_o         (wb_dat_o),
      .wb_dat_i         (wb_dat_i),
      .wb_ack           (wb_ack),
      .done             (done),
      .error_count      (error_count),
      .first_error_addr (first_error_addr)
   );

   tg_wb_mem_model mem_model_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .wb_cyc          (wb_cyc),
      .wb_stb          (wb_stb),
      .wb_we           (wb_we),
      .wb_adr          (wb_adr),
      .wb_dat_i        (wb_dat_o),
      .wb_dat_o        (wb_dat_i),
      .wb_ack          (wb_ack),
      .corrupt_addr_en (corrupt_addr_en),
      .corrupt_addr    (corrupt_addr)
   );

   always #2 clk = ~clk;

   ///////////////////////////////////////////////////////////////////////
   // Failure reporting
   ///////////////////////////////////////////////////////////////////////
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("sim failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      fail_run($sformatf("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Burst tracking
   ///////////////////////////////////////////////////////////////////////
   // One cyc assertion is one burst, so a falling cyc closes it
   assign burst_end  = cyc_q && !wb_cyc;
   assign exp_errors = corrupt_addr_en ? 16'd1 : 16'd0;

   // Length the read pass has to repeat for the current burst
   always_comb
   begin
      exp_len = '0;
      if ((burst_total >= NUM) && (burst_total < 2 * NUM))
         exp_len = write_lens[burst_total - NUM];
   end

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cyc_q       <= 1'b0;
         ack_cnt     <= '0;
         burst_total <= '0;
         exp_adr     <= addr_t'(`TG_BASE_ADDR);
      end
      else if (start)
      begin
         cyc_q       <= 1'b0;
         ack_cnt     <= '0;
         burst_total <= '0;
         exp_adr     <= addr_t'(`TG_BASE_ADDR);
      end
      else
      begin
         cyc_q <= wb_cyc;
         if (wb_cyc && wb_ack)
         begin
            ack_cnt <= ack_cnt + 8'd1;
            exp_adr <= exp_adr + 1'b1;
         end
         if (burst_end)
         begin
            ack_cnt     <= '0;
            burst_total <= burst_total + 8'd1;
            if (burst_total < NUM)
               write_lens[burst_total] <= ack_cnt;
            // The read pass starts over at the base address
            if (burst_total == NUM - 1)
               exp_adr <= addr_t'(`TG_BASE_ADDR);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////
   a_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
      !wb_cyc && !wb_stb && !done && (error_count == '0))
      else fail_run("bus or status active during or right after reset");

   a_len_legal: assert property (@(posedge clk) disable iff (!rst_n) burst_end |->
      (ack_cnt >= `TG_MIN_BURST) && (ack_cnt <= `TG_MAX_BURST) &&
      ((ack_cnt % `TG_BURST_DIV) == 0))
      else fail_run($sformatf("burst of %0d beats has an illegal length", $sampled(ack_cnt)));

   a_read_len: assert property (@(posedge clk) disable iff (!rst_n)
      burst_end && (burst_total >= NUM) |-> ack_cnt == exp_len)
      else report_mismatch("read burst length", $sampled(ack_cnt), $sampled(exp_len));

   a_burst_limit: assert property (@(posedge clk) disable iff (!rst_n)
      burst_end |-> burst_total < 2 * NUM)
      else fail_run("more bursts than two passes need");

   a_adr: assert property (@(posedge clk) disable iff (!rst_n)
      wb_cyc && wb_ack |-> wb_adr == exp_adr)
      else report_mismatch("wb_adr", $sampled(wb_adr), $sampled(exp_adr));

   // Written word is the inverted expected address over that address
   a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
      wb_cyc && wb_ack && wb_we |-> wb_dat_o == {~exp_adr, exp_adr})
      else report_mismatch("wb_dat_o", $sampled(wb_dat_o), $sampled({~exp_adr, exp_adr}));

   a_we: assert property (@(posedge clk) disable iff (!rst_n)
      wb_cyc |-> wb_we == (burst_total < NUM))
      else report_mismatch("wb_we", $sampled(wb_we), $sampled(burst_total < NUM));

   a_hold: assert property (@(posedge clk) disable iff (!rst_n) wb_stb && !wb_ack |=>
      $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o))
      else fail_run("Wishbone request changed while waiting for ack");

   a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
      else fail_run("stb high without cyc");

   a_done_bursts: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(done) |-> burst_total == 2 * NUM)
      else report_mismatch("burst count", $sampled(burst_total), 2 * NUM);

   a_err_count: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(done) |-> error_count == exp_errors)
      else report_mismatch("error_count", $sampled(error_count), $sampled(exp_errors));

   a_first_err: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(done) && corrupt_addr_en |-> first_error_addr == corrupt_addr)
      else report_mismatch("first_error_addr", $sampled(first_error_addr),
                           $sampled(corrupt_addr));

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////
   task automatic pulse_start();
      @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
   endtask

   task automatic wait_done(input int limit);
      int cycles;
      cycles = 0;
      while (!done && (cycles < limit))
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!done)
         fail_run("timeout while waiting for done");
   endtask

   initial
   begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      start           = 1'b0;
      corrupt_addr_en = 1'b0;
      corrupt_addr    = '0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;

      // Clean run
      pulse_start();
      wait_done(DONE_TIMEOUT);

      // Second beat of the first burst reads back with bit 0 flipped
      @(posedge clk);
      #1;
      corrupt_addr    = addr_t'(`TG_BASE_ADDR + 1);
      corrupt_addr_en = 1'b1;
      pulse_start();
      wait_done(DONE_TIMEOUT);

      repeat (2) @(posedge clk);
      $display("sim passed");
      $finish;
   end

endmodule

//--- verif/tg_wb_mem_model.sv
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave memory of 64K words for the testbench
// Ack after 0 to 3 random wait cycles, optional bit 0 flip on reads
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

module tg_wb_mem_model (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          wb_cyc,
   input  logic          wb_stb,
   input  logic          wb_we,
   input  tg_pkg::addr_t wb_adr,
   input  tg_pkg::data_t wb_dat_i,
   output tg_pkg::data_t wb_dat_o,
   output logic          wb_ack,
   input  logic          corrupt_addr_en,
   input  tg_pkg::addr_t corrupt_addr
);
   import tg_pkg::*;

   localparam int DEPTH = 1 << `TG_ADDR_WIDTH;

   data_t      mem [0:DEPTH-1];
   logic [1:0] wait_left;
   logic       corrupt_hit;
   integer     seed = 32'h2d94_c5a5;
   integer     draw;

   // The fill swaps the halves of the write pattern, so every unwritten word reads wrong
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = {addr_t'(i), ~addr_t'(i)};
   end

   // Only reads of the chosen address are corrupted
   assign corrupt_hit = corrupt_addr_en && !wb_we && (wb_adr == corrupt_addr);
   assign wb_dat_o    = mem[wb_adr] ^ {{(`TG_DATA_WIDTH-1){1'b0}}, corrupt_hit};

   // Ack comes as soon as the wait counter of this beat has run out
   assign wb_ack = wb_cyc && wb_stb && (wait_left == 2'd0);

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wait_left <= 2'd0;
      else if (wb_ack)
      begin
         // New wait for the next beat, drawn when this one ends
         draw = $random(seed);
         wait_left <= draw[1:0];
         if (wb_we)
            mem[wb_adr] <= wb_dat_i;
      end
      else if (wb_stb && (wait_left != 2'd0))
         wait_left <= wait_left - 2'd1;
   end

endmodule

//--- verilog/tg_top.sv
//////////////////////////////////////////////////////////////////////
// Memory traffic generator with a single Wishbone classic master port
//////////////////////////////////////////////////////////////////////
module tg_top (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          start,
   output logic          wb_cyc,
   output logic          wb_stb,
   output logic          wb_we,
   output tg_pkg::addr_t wb_adr,
   output tg_pkg::data_t wb_dat_o,
   input  tg_pkg::data_t wb_dat_i,
   input  logic          wb_ack,
   output logic          done,
   output logic [15:0]   error_count,
   output tg_pkg::addr_t first_error_addr
);
   import tg_pkg::*;

   // Decode to execute command channel
   tg_cmd_t  cmd;
   logic     cmd_valid;
   logic     cmd_ready;
   logic     burst_done;
   // Execute and decode to result
   tg_beat_t beat;
   logic     beat_valid;
   logic     run_end;

   tg_cmd_decode cmd_decode_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .burst_done (burst_done),
      .run_end    (run_end)
   );

   tg_wb_execute wb_execute_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .burst_done (burst_done),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_dat_i   (wb_dat_i),
      .wb_ack     (wb_ack),
      .beat       (beat),
      .beat_valid (beat_valid)
   );

   tg_result_check result_check_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .start            (start),
      .beat             (beat),
      .beat_valid       (beat_valid),
      .run_end          (run_end),
      .done             (done),
      .error_count      (error_count),
      .first_error_addr (first_error_addr)
   );

endmodule

//--- verilog/tg_result_check.sv
//////////////////////////////////////////////////////////////////////
// Read data checker, the error count saturates at all ones
//////////////////////////////////////////////////////////////////////
module tg_result_check (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             start,
   input  tg_pkg::tg_beat_t beat,
   input  logic             beat_valid,
   input  logic             run_end,
   output logic             done,
   output logic [15:0]      error_count,
   output tg_pkg::addr_t    first_error_addr
);
   import tg_pkg::*;

   logic mismatch;
   logic error_seen;

   // Expected word is rebuilt from the beat's own address
   assign mismatch = beat_valid && (beat.data != tg_pattern(beat.addr));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         done             <= 1'b0;
         error_count      <= '0;
         error_seen       <= 1'b0;
         first_error_addr <= '0;
      end
      // A new run wipes the previous status
      else if (start)
      begin
         done             <= 1'b0;
         error_count      <= '0;
         error_seen       <= 1'b0;
         first_error_addr <= '0;
      end
      else
      begin
         // done stays up until the next start
         if (run_end)
            done <= 1'b1;
         if (mismatch)
         begin
            if (error_count != '1)
               error_count <= error_count + 1'b1;
            // Only the first failing address is kept
            if (!error_seen)
            begin
               error_seen       <= 1'b1;
               first_error_addr <= beat.addr;
            end
         end
      end
   end

endmodule

//--- verilog/tg_wb_execute.sv
//////////////////////////////////////////////////////////////////////
// Wishbone classic master for one burst at a time, no byte selects,
// no err or rty; a zero length command is not supported
//////////////////////////////////////////////////////////////////////
module tg_wb_execute (
   input  logic             clk,
   input  logic             rst_n,
   input  tg_pkg::tg_cmd_t  cmd,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   output logic             burst_done,
   output logic             wb_cyc,
   output logic             wb_stb,
   output logic             wb_we,
   output tg_pkg::addr_t    wb_adr,
   output tg_pkg::data_t    wb_dat_o,
   input  tg_pkg::data_t    wb_dat_i,
   input  logic             wb_ack,
   output tg_pkg::tg_beat_t beat,
   output logic             beat_valid
);
   import tg_pkg::*;

   exec_state_e state;
   tg_pass_e    pass;
   burst_len_t  remaining;
   logic        beat_ack;

   assign cmd_ready = (state == EXEC_IDLE);

   // cyc covers the whole burst, and it drops in idle between bursts
   assign wb_cyc   = (state == EXEC_BUS);
   assign wb_stb   = wb_cyc;
   assign wb_we    = wb_cyc && (pass == PASS_WRITE);
   assign wb_dat_o = tg_pattern(wb_adr);
   assign beat_ack = wb_stb && wb_ack;

   ///////////////////////////////////////////////////////////////////////
   // Beat counting
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= EXEC_IDLE;
         pass       <= PASS_WRITE;
         remaining  <= '0;
         burst_done <= 1'b0;
         beat_valid <= 1'b0;
      end
      else
      begin
         burst_done <= 1'b0;
         beat_valid <= beat_ack && (pass == PASS_READ);
         case (state)
            EXEC_IDLE:
               if (cmd_valid)
               begin
                  pass      <= cmd.pass;
                  remaining <= cmd.len;
                  state     <= EXEC_BUS;
               end
            EXEC_BUS:
               if (wb_ack)
               begin
                  remaining <= remaining - 1'b1;
                  // Last beat closes the cycle and reports the burst
                  if (remaining == burst_len_t'(1))
                  begin
                     state      <= EXEC_IDLE;
                     burst_done <= 1'b1;
                  end
               end
            default:
               state <= EXEC_IDLE;
         endcase
      end
   end

   // Address walks up by one per ack and stays put while the slave stalls
   always_ff @(posedge clk)
   begin
      if (cmd_valid && cmd_ready)
         wb_adr <= cmd.base;
      else if (beat_ack)
         wb_adr <= wb_adr + 1'b1;
      if (beat_ack)
      begin
         beat.addr <= wb_adr;
         beat.data <= wb_dat_i;
      end
   end

   a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                            $stable(wb_dat_o))
      else $error("Wishbone request changed before ack");

endmodule

//--- verilog/tg_cmd_decode.sv
//////////////////////////////////////////////////////////////////////
// Write pass then read pass of TG_NUM_BURSTS bursts each, one command
// in flight at a time; start is ignored while a run is active
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

module tg_cmd_decode (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            start,
   output tg_pkg::tg_cmd_t cmd,
   output logic            cmd_valid,
   input  logic            cmd_ready,
   input  logic            burst_done,
   output logic            run_end
);
   import tg_pkg::*;

   localparam int CNT_W = $clog2(`TG_NUM_BURSTS + 1);

   decode_state_e    state;
   tg_pass_e         pass;
   addr_t            next_addr;
   logic [CNT_W-1:0] burst_cnt;
   logic             last_burst;
   logic             len_enable;
   logic             len_ready;
   logic             reseed;
   burst_len_t       burstcount;

   assign len_enable = (state == DEC_GET_LEN);
   assign cmd_valid  = (state == DEC_ISSUE);
   assign last_burst = (burst_cnt == CNT_W'(`TG_NUM_BURSTS - 1));

   // Reseed on start and when the write pass hands over to the read pass
   assign reseed = ((state == DEC_IDLE) && start) ||
                   ((state == DEC_WAIT_DONE) && burst_done && last_burst &&
                    (pass == PASS_WRITE));

   tg_rand_burstcount_gen #(.POW2_ONLY(1'b0)) burstcount_gen_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .reseed     (reseed),
      .enable     (len_enable),
      .ready      (len_ready),
      .burstcount (burstcount)
   );

   ///////////////////////////////////////////////////////////////////////
   // Pass and burst sequencing
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= DEC_IDLE;
         pass      <= PASS_WRITE;
         next_addr <= `TG_BASE_ADDR;
         burst_cnt <= '0;
         run_end   <= 1'b0;
      end
      else
      begin
         run_end <= 1'b0;
         case (state)
            DEC_IDLE:
               if (start)
               begin
                  pass      <= PASS_WRITE;
                  next_addr <= `TG_BASE_ADDR;
                  burst_cnt <= '0;
                  state     <= DEC_GET_LEN;
               end
            // Bursts sit back to back, so the next base follows the length
            DEC_GET_LEN:
               if (len_ready)
               begin
                  next_addr <= next_addr + addr_t'(burstcount);
                  state     <= DEC_ISSUE;
               end
            DEC_ISSUE:
               if (cmd_ready)
                  state <= DEC_WAIT_DONE;
            DEC_WAIT_DONE:
               if (burst_done)
               begin
                  burst_cnt <= burst_cnt + 1'b1;
                  state     <= DEC_GET_LEN;
                  if (last_burst)
                  begin
                     burst_cnt <= '0;
                     if (pass == PASS_WRITE)
                     begin
                        pass      <= PASS_READ;
                        next_addr <= `TG_BASE_ADDR;
                     end
                     else
                     begin
                        run_end <= 1'b1;
                        state   <= DEC_IDLE;
                     end
                  end
               end
            default:
               state <= DEC_IDLE;
         endcase
      end
   end

   // Command is built from the consumed length and shows up one cycle later
   always_ff @(posedge clk)
   begin
      if (len_enable && len_ready)
      begin
         cmd.pass <= pass;
         cmd.base <= next_addr;
         cmd.len  <= burstcount;
      end
   end

endmodule

//--- verilog/tg_rand_burstcount_gen.sv
//////////////////////////////////////////////////////////////////////
// Random burst lengths in the configured range, rounded down to the
// divisor; the effective minimum is never below the divisor
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

module tg_rand_burstcount_gen #(
   parameter bit POW2_ONLY = 1'b0
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               reseed,
   input  logic               enable,
   output logic               ready,
   output tg_pkg::burst_len_t burstcount
);
   import tg_pkg::*;

   localparam int MIN_EFF = (`TG_MIN_BURST < `TG_BURST_DIV) ? `TG_BURST_DIV : `TG_MIN_BURST;
   // Ceil and floor of log2 for the exponent range
   localparam int MIN_EXP = $clog2(MIN_EFF);
   localparam int MAX_EXP = $clog2(`TG_MAX_BURST + 1) - 1;
   localparam burst_len_t DIV_MASK = ~burst_len_t'(`TG_BURST_DIV - 1);

   burst_len_t raw_len;
   burst_len_t rand_out;

   generate
      if (POW2_ONLY)
      begin : g_pow2
         // Draw an exponent and turn it into a power of two
         tg_rand_num_gen #(.RAND_MIN(MIN_EXP), .RAND_MAX(MAX_EXP)) rand_exp_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .reseed   (reseed),
            .enable   (enable),
            .ready    (ready),
            .rand_num (rand_out)
         );
         assign raw_len = burst_len_t'(1) << rand_out;
      end
      else
      begin : g_direct
         tg_rand_num_gen #(.RAND_MIN(MIN_EFF), .RAND_MAX(`TG_MAX_BURST)) rand_len_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .reseed   (reseed),
            .enable   (enable),
            .ready    (ready),
            .rand_num (rand_out)
         );
         assign raw_len = rand_out;
      end
   endgenerate

   // Round down to the divisor, which cannot reach zero since MIN_EFF >= divisor
   assign burstcount = raw_len & DIV_MASK;

   a_legal_len: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> (burstcount != '0) && ((burstcount & ~DIV_MASK) == '0) &&
                (burstcount >= MIN_EFF) && (burstcount <= `TG_MAX_BURST))
      else $error("illegal burst length");

endmodule

//--- verilog/tg_rand_num_gen.sv
//////////////////////////////////////////////////////////////////////
// Bounded random numbers from a 16-bit LFSR, RAND_MAX must fit in
// burst_len_t and the range must be reachable by the low LFSR bits
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

module tg_rand_num_gen #(
   parameter int RAND_MIN = 1,
   parameter int RAND_MAX = 1
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               reseed,
   input  logic               enable,
   output logic               ready,
   output tg_pkg::burst_len_t rand_num
);
   import tg_pkg::*;

   logic [15:0] lfsr;
   logic [15:0] lfsr_next;
   burst_len_t  candidate;
   logic        in_range;
   logic        consume;

   // Galois form of x^16 + x^14 + x^13 + x^11 + 1
   assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);

   // Candidates come from the low bits and are rejected when out of range
   assign candidate = lfsr[`TG_BURST_WIDTH-1:0];
   assign in_range  = (candidate >= RAND_MIN) && (candidate <= RAND_MAX);
   assign consume   = ready && enable;

   // The LFSR only freezes while a value is held, so the sequence of
   // accepted values after a reseed does not depend on the consumer's timing
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr  <= `TG_LFSR_SEED;
         ready <= 1'b0;
      end
      else if (reseed)
      begin
         lfsr  <= `TG_LFSR_SEED;
         ready <= 1'b0;
      end
      else if (consume)
      begin
         lfsr  <= lfsr_next;
         ready <= 1'b0;
      end
      else if (!ready)
      begin
         lfsr  <= lfsr_next;
         ready <= in_range;
      end
   end

   // Held value, loaded on the same cycle that ready rises
   always_ff @(posedge clk)
   begin
      if (!ready && !reseed && in_range)
         rand_num <= candidate;
   end

   a_range: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> (rand_num >= RAND_MIN) && (rand_num <= RAND_MAX))
      else $error("random number outside its range");

endmodule

//--- verilog/tg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the traffic generator
//////////////////////////////////////////////////////////////////////
`include "tg_settings.svh"

package tg_pkg;

   typedef logic [`TG_ADDR_WIDTH-1:0]  addr_t;
   typedef logic [`TG_DATA_WIDTH-1:0]  data_t;
   typedef logic [`TG_BURST_WIDTH-1:0] burst_len_t;

   typedef enum logic {PASS_WRITE, PASS_READ} tg_pass_e;

   // One burst as handed from decode to execute
   typedef struct packed {
      tg_pass_e   pass;
      addr_t      base;
      burst_len_t len;
   } tg_cmd_t;

   // One acknowledged read beat as handed from execute to result
   typedef struct packed {
      addr_t addr;
      data_t data;
   } tg_beat_t;

   typedef enum logic [1:0] {DEC_IDLE, DEC_GET_LEN, DEC_ISSUE, DEC_WAIT_DONE} decode_state_e;

   typedef enum logic {EXEC_IDLE, EXEC_BUS} exec_state_e;

   // Expected word at an address, inverted address on top of the address
   function automatic data_t tg_pattern(addr_t a);
      return {~a, a};
   endfunction

endpackage

//--- verilog/tg_settings.svh
//////////////////////////////////////////////////////////////////////
// Fixed build-time settings of the traffic generator
// TG_DATA_WIDTH must stay twice TG_ADDR_WIDTH for the data pattern
//////////////////////////////////////////////////////////////////////
`ifndef TG_SETTINGS_SVH
`define TG_SETTINGS_SVH

// Word address and data widths
`define TG_ADDR_WIDTH  16
`define TG_DATA_WIDTH  32

// Burst length range, the divisor must be a power of two
`define TG_BURST_WIDTH 6
`define TG_MIN_BURST   2
`define TG_MAX_BURST   16
`define TG_BURST_DIV   2

// Run shape and LFSR reload value, the seed must be nonzero
`define TG_NUM_BURSTS  8
`define TG_BASE_ADDR   16'h0100
`define TG_LFSR_SEED   16'hace1

`endif
